// ==== pad_ctrl_pkg.sv ====
/* Shared pad frame definitions: pad indices, mode codes, widths,
   peripheral bundles and the timer bus union */
`default_nettype none

package pad_ctrl_pkg;

   ////////////////////
   // Sizes
   ////////////////////
   localparam int unsigned NUM_PADS   = 28;
   localparam int unsigned MODE_W     = 2;
   localparam int unsigned CFG_W      = 6;
   localparam int unsigned GPIO_W     = NUM_PADS;
   localparam int unsigned NUM_TIMERS = 4;
   localparam int unsigned TIMER_CH_W = 4;

   // Per-pad mode codes
   localparam logic [MODE_W-1:0] MODE_FUNC = 2'd0;
   localparam logic [MODE_W-1:0] MODE_GPIO = 2'd1;
   localparam logic [MODE_W-1:0] MODE_ALT  = 2'd2;
   localparam logic [MODE_W-1:0] MODE_OFF  = 2'd3;

   ////////////////////
   // Pad indices
   ////////////////////
   localparam int unsigned PAD_SPIM_SDIO0 = 0;
   localparam int unsigned PAD_SPIM_SDIO1 = 1;
   localparam int unsigned PAD_SPIM_SDIO2 = 2;
   localparam int unsigned PAD_SPIM_SDIO3 = 3;
   localparam int unsigned PAD_SPIM_CSN0  = 4;
   localparam int unsigned PAD_SPIM_CSN1  = 5;
   localparam int unsigned PAD_SPIM_SCK   = 6;
   localparam int unsigned PAD_UART_RX    = 7;
   localparam int unsigned PAD_UART_TX    = 8;
   localparam int unsigned PAD_CAM_PCLK   = 9;
   localparam int unsigned PAD_CAM_HSYNC  = 10;
   localparam int unsigned PAD_CAM_DATA0  = 11;
   localparam int unsigned PAD_CAM_DATA1  = 12;
   localparam int unsigned PAD_CAM_DATA2  = 13;
   localparam int unsigned PAD_CAM_DATA3  = 14;
   localparam int unsigned PAD_CAM_DATA4  = 15;
   localparam int unsigned PAD_CAM_DATA5  = 16;
   localparam int unsigned PAD_CAM_DATA6  = 17;
   localparam int unsigned PAD_CAM_DATA7  = 18;
   localparam int unsigned PAD_CAM_VSYNC  = 19;
   localparam int unsigned PAD_SDIO_CLK   = 20;
   localparam int unsigned PAD_SDIO_CMD   = 21;
   localparam int unsigned PAD_SDIO_DATA0 = 22;
   localparam int unsigned PAD_SDIO_DATA1 = 23;
   localparam int unsigned PAD_SDIO_DATA2 = 24;
   localparam int unsigned PAD_SDIO_DATA3 = 25;
   localparam int unsigned PAD_I2C0_SDA   = 26;
   localparam int unsigned PAD_I2C0_SCL   = 27;

   // Timer outputs share the camera pads and the SDIO clock pad
   localparam int unsigned PAD_CAM_FIRST  = 9;
   localparam int unsigned PAD_TIMER_LAST = 20;

   ////////////////////
   // Bundles
   ////////////////////
   typedef struct packed {
      logic       sck;
      logic [1:0] csn;
      logic [3:0] sdo;
      logic [3:0] oen;
   } spi_out_t;

   typedef struct packed {
      logic       clk;
      logic       cmd;
      logic       cmd_oen;
      logic [3:0] data;
      logic [3:0] data_oen;
   } sdio_out_t;

   typedef struct packed {
      logic scl_out;
      logic scl_oe;
      logic sda_out;
      logic sda_oe;
   } i2c_out_t;

   typedef struct packed {
      logic [NUM_PADS-1:0] out;
      logic [NUM_PADS-1:0] oe;
   } pad_drive_t;

   // Index 0 is I2C0, index 1 is I2C1
   typedef struct packed {
      logic [3:0] spi_sdi;
      logic       sdio_cmd;
      logic [3:0] sdio_data;
      logic       uart_rx;
      logic [1:0] i2c_sda_in;
      logic [1:0] i2c_scl_in;
   } periph_in_t;

   // Timers deliver per channel, pads consume by flat bit
   typedef union packed {
      logic [NUM_TIMERS*TIMER_CH_W-1:0]           flat;
      logic [NUM_TIMERS-1:0][TIMER_CH_W-1:0]      ch;
   } timer_bus_u;

endpackage

`default_nettype wire

// ==== pad_func_map.sv ====
/* Fixed peripheral to pad assignment for function and alternate modes */
`default_nettype none

module pad_func_map (
   input  pad_ctrl_pkg::spi_out_t   spi_i,
   input  pad_ctrl_pkg::sdio_out_t  sdio_i,
   input  pad_ctrl_pkg::i2c_out_t   i2c0_i,
   input  pad_ctrl_pkg::i2c_out_t   i2c1_i,
   input  logic                     uart_tx_i,
   input  pad_ctrl_pkg::timer_bus_u timer_i,
   output pad_ctrl_pkg::pad_drive_t func_drive_o,
   output pad_ctrl_pkg::pad_drive_t alt_drive_o
);

   ////////////////////
   // Function mode
   ////////////////////
   always_comb begin
      // Pad 7 (UART RX) and the camera pads stay undriven
      func_drive_o = '0;

      for (int k = 0; k < 4; k++) begin
         func_drive_o.out[pad_ctrl_pkg::PAD_SPIM_SDIO0 + k] = spi_i.sdo[k];
         func_drive_o.oe[pad_ctrl_pkg::PAD_SPIM_SDIO0 + k]  = ~spi_i.oen[k];
      end

      func_drive_o.out[pad_ctrl_pkg::PAD_SPIM_CSN0] = spi_i.csn[0];
      func_drive_o.oe[pad_ctrl_pkg::PAD_SPIM_CSN0]  = 1'b1;
      func_drive_o.out[pad_ctrl_pkg::PAD_SPIM_CSN1] = spi_i.csn[1];
      func_drive_o.oe[pad_ctrl_pkg::PAD_SPIM_CSN1]  = 1'b1;
      func_drive_o.out[pad_ctrl_pkg::PAD_SPIM_SCK]  = spi_i.sck;
      func_drive_o.oe[pad_ctrl_pkg::PAD_SPIM_SCK]   = 1'b1;

      func_drive_o.out[pad_ctrl_pkg::PAD_UART_TX] = uart_tx_i;
      func_drive_o.oe[pad_ctrl_pkg::PAD_UART_TX]  = 1'b1;

      func_drive_o.out[pad_ctrl_pkg::PAD_SDIO_CLK] = sdio_i.clk;
      func_drive_o.oe[pad_ctrl_pkg::PAD_SDIO_CLK]  = 1'b1;
      func_drive_o.out[pad_ctrl_pkg::PAD_SDIO_CMD] = sdio_i.cmd;
      func_drive_o.oe[pad_ctrl_pkg::PAD_SDIO_CMD]  = ~sdio_i.cmd_oen;

      for (int k = 0; k < 4; k++) begin
         func_drive_o.out[pad_ctrl_pkg::PAD_SDIO_DATA0 + k] = sdio_i.data[k];
         func_drive_o.oe[pad_ctrl_pkg::PAD_SDIO_DATA0 + k]  = ~sdio_i.data_oen[k];
      end

      // I2C0 enables are already active high
      func_drive_o.out[pad_ctrl_pkg::PAD_I2C0_SDA] = i2c0_i.sda_out;
      func_drive_o.oe[pad_ctrl_pkg::PAD_I2C0_SDA]  = i2c0_i.sda_oe;
      func_drive_o.out[pad_ctrl_pkg::PAD_I2C0_SCL] = i2c0_i.scl_out;
      func_drive_o.oe[pad_ctrl_pkg::PAD_I2C0_SCL]  = i2c0_i.scl_oe;
   end

   ////////////////////
   // Alternate mode
   ////////////////////
   always_comb begin
      alt_drive_o = '0;

      // I2C1 on three candidate pad pairs
      alt_drive_o.out[pad_ctrl_pkg::PAD_SPIM_SDIO2] = i2c1_i.sda_out;
      alt_drive_o.oe[pad_ctrl_pkg::PAD_SPIM_SDIO2]  = i2c1_i.sda_oe;
      alt_drive_o.out[pad_ctrl_pkg::PAD_SPIM_SDIO3] = i2c1_i.scl_out;
      alt_drive_o.oe[pad_ctrl_pkg::PAD_SPIM_SDIO3]  = i2c1_i.scl_oe;

      alt_drive_o.out[pad_ctrl_pkg::PAD_UART_RX] = i2c1_i.sda_out;
      alt_drive_o.oe[pad_ctrl_pkg::PAD_UART_RX]  = i2c1_i.sda_oe;
      alt_drive_o.out[pad_ctrl_pkg::PAD_UART_TX] = i2c1_i.scl_out;
      alt_drive_o.oe[pad_ctrl_pkg::PAD_UART_TX]  = i2c1_i.scl_oe;

      alt_drive_o.out[pad_ctrl_pkg::PAD_SDIO_DATA2] = i2c1_i.sda_out;
      alt_drive_o.oe[pad_ctrl_pkg::PAD_SDIO_DATA2]  = i2c1_i.sda_oe;
      alt_drive_o.out[pad_ctrl_pkg::PAD_SDIO_DATA3] = i2c1_i.scl_out;
      alt_drive_o.oe[pad_ctrl_pkg::PAD_SDIO_DATA3]  = i2c1_i.scl_oe;

      // Timer bits in flat order, always driven
      for (int p = pad_ctrl_pkg::PAD_CAM_FIRST; p <= pad_ctrl_pkg::PAD_TIMER_LAST; p++) begin
         alt_drive_o.out[p] = timer_i.flat[p - pad_ctrl_pkg::PAD_CAM_FIRST];
         alt_drive_o.oe[p]  = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== pad_out_mux.sv ====
/* Per-pad output, output enable and configuration select by pad mode */
`default_nettype none

module pad_out_mux (
   input  logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::MODE_W-1:0] pad_mode_i,
   input  pad_ctrl_pkg::pad_drive_t                                     func_drive_i,
   input  pad_ctrl_pkg::pad_drive_t                                     alt_drive_i,
   input  logic [pad_ctrl_pkg::GPIO_W-1:0]                              gpio_out_i,
   input  logic [pad_ctrl_pkg::GPIO_W-1:0]                              gpio_dir_i,
   input  logic [pad_ctrl_pkg::GPIO_W-1:0][pad_ctrl_pkg::CFG_W-1:0]     gpio_cfg_i,
   input  logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::CFG_W-1:0]   pad_cfg_i,
   output logic [pad_ctrl_pkg::NUM_PADS-1:0]                            pad_out_o,
   output logic [pad_ctrl_pkg::NUM_PADS-1:0]                            pad_oe_o,
   output logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::CFG_W-1:0]   pad_cfg_o
);

   for (genvar p = 0; p < pad_ctrl_pkg::NUM_PADS; p++) begin : g_pad
      always_comb begin
         // Default register config unless GPIO owns the pad
         pad_cfg_o[p] = pad_cfg_i[p];

         case (pad_mode_i[p])
            pad_ctrl_pkg::MODE_FUNC: begin
               pad_out_o[p] = func_drive_i.out[p];
               pad_oe_o[p]  = func_drive_i.oe[p];
            end
            pad_ctrl_pkg::MODE_GPIO: begin
               pad_out_o[p] = gpio_out_i[p];
               pad_oe_o[p]  = gpio_dir_i[p];
               pad_cfg_o[p] = gpio_cfg_i[p];
            end
            pad_ctrl_pkg::MODE_ALT: begin
               pad_out_o[p] = alt_drive_i.out[p];
               pad_oe_o[p]  = alt_drive_i.oe[p];
            end
            default: begin
               // Off
               pad_out_o[p] = 1'b0;
               pad_oe_o[p]  = 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== pad_in_route.sv ====
/* Pad input return path to the owning peripherals and to GPIO */
`default_nettype none

module pad_in_route (
   input  logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::MODE_W-1:0] pad_mode_i,
   input  logic [pad_ctrl_pkg::NUM_PADS-1:0]                            pad_in_i,
   output pad_ctrl_pkg::periph_in_t                                     periph_o,
   output logic [pad_ctrl_pkg::GPIO_W-1:0]                              gpio_in_o
);

   logic [pad_ctrl_pkg::NUM_PADS-1:0] is_func;
   logic [pad_ctrl_pkg::NUM_PADS-1:0] is_alt;

   ////////////////////
   // Mode decode
   ////////////////////
   for (genvar p = 0; p < pad_ctrl_pkg::NUM_PADS; p++) begin : g_dec
      assign is_func[p]   = (pad_mode_i[p] == pad_ctrl_pkg::MODE_FUNC);
      assign is_alt[p]    = (pad_mode_i[p] == pad_ctrl_pkg::MODE_ALT);
      assign gpio_in_o[p] = (pad_mode_i[p] == pad_ctrl_pkg::MODE_GPIO) & pad_in_i[p];
   end

   ////////////////////
   // Peripheral inputs
   ////////////////////
   always_comb begin
      // Data lines park low
      for (int k = 0; k < 4; k++) begin
         periph_o.spi_sdi[k] = is_func[pad_ctrl_pkg::PAD_SPIM_SDIO0 + k]
                             & pad_in_i[pad_ctrl_pkg::PAD_SPIM_SDIO0 + k];
         periph_o.sdio_data[k] = is_func[pad_ctrl_pkg::PAD_SDIO_DATA0 + k]
                               & pad_in_i[pad_ctrl_pkg::PAD_SDIO_DATA0 + k];
      end
      periph_o.sdio_cmd = is_func[pad_ctrl_pkg::PAD_SDIO_CMD]
                        & pad_in_i[pad_ctrl_pkg::PAD_SDIO_CMD];

      // UART and I2C idle high
      periph_o.uart_rx = is_func[pad_ctrl_pkg::PAD_UART_RX] ?
                         pad_in_i[pad_ctrl_pkg::PAD_UART_RX] : 1'b1;
      periph_o.i2c_sda_in[0] = is_func[pad_ctrl_pkg::PAD_I2C0_SDA] ?
                               pad_in_i[pad_ctrl_pkg::PAD_I2C0_SDA] : 1'b1;
      periph_o.i2c_scl_in[0] = is_func[pad_ctrl_pkg::PAD_I2C0_SCL] ?
                               pad_in_i[pad_ctrl_pkg::PAD_I2C0_SCL] : 1'b1;

      // I2C1, lowest candidate pad wins
      if (is_alt[pad_ctrl_pkg::PAD_SPIM_SDIO2]) begin
         periph_o.i2c_sda_in[1] = pad_in_i[pad_ctrl_pkg::PAD_SPIM_SDIO2];
      end else if (is_alt[pad_ctrl_pkg::PAD_UART_RX]) begin
         periph_o.i2c_sda_in[1] = pad_in_i[pad_ctrl_pkg::PAD_UART_RX];
      end else if (is_alt[pad_ctrl_pkg::PAD_SDIO_DATA2]) begin
         periph_o.i2c_sda_in[1] = pad_in_i[pad_ctrl_pkg::PAD_SDIO_DATA2];
      end else begin
         periph_o.i2c_sda_in[1] = 1'b1;
      end

      if (is_alt[pad_ctrl_pkg::PAD_SPIM_SDIO3]) begin
         periph_o.i2c_scl_in[1] = pad_in_i[pad_ctrl_pkg::PAD_SPIM_SDIO3];
      end else if (is_alt[pad_ctrl_pkg::PAD_UART_TX]) begin
         periph_o.i2c_scl_in[1] = pad_in_i[pad_ctrl_pkg::PAD_UART_TX];
      end else if (is_alt[pad_ctrl_pkg::PAD_SDIO_DATA3]) begin
         periph_o.i2c_scl_in[1] = pad_in_i[pad_ctrl_pkg::PAD_SDIO_DATA3];
      end else begin
         periph_o.i2c_scl_in[1] = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== pad_ctrl_top.sv ====
/* Pad multiplexer top level: function map, output select and input routing */
`default_nettype none

module pad_ctrl_top (
   // Pad control registers
   input  logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::MODE_W-1:0] pad_mode_i,
   input  logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::CFG_W-1:0]  pad_cfg_i,
   output logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::CFG_W-1:0]  pad_cfg_o,

   // GPIO
   input  logic [pad_ctrl_pkg::GPIO_W-1:0]                             gpio_out_i,
   input  logic [pad_ctrl_pkg::GPIO_W-1:0]                             gpio_dir_i,
   input  logic [pad_ctrl_pkg::GPIO_W-1:0][pad_ctrl_pkg::CFG_W-1:0]    gpio_cfg_i,
   output logic [pad_ctrl_pkg::GPIO_W-1:0]                             gpio_in_o,

   // Peripherals
   input  pad_ctrl_pkg::spi_out_t                                      spi_i,
   input  pad_ctrl_pkg::sdio_out_t                                     sdio_i,
   input  pad_ctrl_pkg::i2c_out_t                                      i2c0_i,
   input  pad_ctrl_pkg::i2c_out_t                                      i2c1_i,
   input  logic                                                        uart_tx_i,
   input  pad_ctrl_pkg::timer_bus_u                                    timer_i,
   output pad_ctrl_pkg::periph_in_t                                    periph_o,

   // Pad frame
   input  logic [pad_ctrl_pkg::NUM_PADS-1:0]                           pad_in_i,
   output logic [pad_ctrl_pkg::NUM_PADS-1:0]                           pad_out_o,
   output logic [pad_ctrl_pkg::NUM_PADS-1:0]                           pad_oe_o
);

   pad_ctrl_pkg::pad_drive_t func_drive;
   pad_ctrl_pkg::pad_drive_t alt_drive;

   ////////////////////
   // Output path
   ////////////////////
   pad_func_map u_func_map (
      .spi_i        (spi_i),
      .sdio_i       (sdio_i),
      .i2c0_i       (i2c0_i),
      .i2c1_i       (i2c1_i),
      .uart_tx_i    (uart_tx_i),
      .timer_i      (timer_i),
      .func_drive_o (func_drive),
      .alt_drive_o  (alt_drive)
   );

   pad_out_mux u_out_mux (
      .pad_mode_i   (pad_mode_i),
      .func_drive_i (func_drive),
      .alt_drive_i  (alt_drive),
      .gpio_out_i   (gpio_out_i),
      .gpio_dir_i   (gpio_dir_i),
      .gpio_cfg_i   (gpio_cfg_i),
      .pad_cfg_i    (pad_cfg_i),
      .pad_out_o    (pad_out_o),
      .pad_oe_o     (pad_oe_o),
      .pad_cfg_o    (pad_cfg_o)
   );

   ////////////////////
   // Input path
   ////////////////////
   pad_in_route u_in_route (
      .pad_mode_i (pad_mode_i),
      .pad_in_i   (pad_in_i),
      .periph_o   (periph_o),
      .gpio_in_o  (gpio_in_o)
   );

endmodule

`default_nettype wire

// ==== tb_pad_ctrl.sv ====
/* Self-checking testbench for the pad multiplexer: reference model of the
   pad tables, directed and random stimulus, checks on the falling edge */
`default_nettype none

module tb_pad_ctrl;

   localparam int RANDOM_CYCLES  = 300;
   localparam int TIMEOUT_CYCLES = 600;
   localparam int SEED           = 97226;

   // Everything the DUT reads, applied as one word per cycle
   typedef struct packed {
      logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::MODE_W-1:0] mode;
      logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::CFG_W-1:0]  pad_cfg;
      logic [pad_ctrl_pkg::GPIO_W-1:0]                             gpio_out;
      logic [pad_ctrl_pkg::GPIO_W-1:0]                             gpio_dir;
      logic [pad_ctrl_pkg::GPIO_W-1:0][pad_ctrl_pkg::CFG_W-1:0]    gpio_cfg;
      pad_ctrl_pkg::spi_out_t                                      spi;
      pad_ctrl_pkg::sdio_out_t                                     sdio;
      pad_ctrl_pkg::i2c_out_t                                      i2c0;
      pad_ctrl_pkg::i2c_out_t                                      i2c1;
      logic                                                        uart_tx;
      pad_ctrl_pkg::timer_bus_u                                    timer;
      logic [pad_ctrl_pkg::NUM_PADS-1:0]                           pad_in;
   } stim_t;

   typedef struct packed {
      logic [pad_ctrl_pkg::NUM_PADS-1:0]                          out;
      logic [pad_ctrl_pkg::NUM_PADS-1:0]                          oe;
      logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::CFG_W-1:0] cfg;
      logic [pad_ctrl_pkg::GPIO_W-1:0]                            gpio_in;
      pad_ctrl_pkg::periph_in_t                                   periph;
   } resp_t;

   logic  clk;
   logic  rst_n;
   stim_t stim;
   int    errors;
   int    num_checks;

   logic [pad_ctrl_pkg::NUM_PADS-1:0]                          pad_out;
   logic [pad_ctrl_pkg::NUM_PADS-1:0]                          pad_oe;
   logic [pad_ctrl_pkg::NUM_PADS-1:0][pad_ctrl_pkg::CFG_W-1:0] pad_cfg;
   logic [pad_ctrl_pkg::GPIO_W-1:0]                            gpio_in;
   pad_ctrl_pkg::periph_in_t                                   periph;

   pad_ctrl_top DUT (
      .pad_mode_i (stim.mode),
      .pad_cfg_i  (stim.pad_cfg),
      .pad_cfg_o  (pad_cfg),
      .gpio_out_i (stim.gpio_out),
      .gpio_dir_i (stim.gpio_dir),
      .gpio_cfg_i (stim.gpio_cfg),
      .gpio_in_o  (gpio_in),
      .spi_i      (stim.spi),
      .sdio_i     (stim.sdio),
      .i2c0_i     (stim.i2c0),
      .i2c1_i     (stim.i2c1),
      .uart_tx_i  (stim.uart_tx),
      .timer_i    (stim.timer),
      .periph_o   (periph),
      .pad_in_i   (stim.pad_in),
      .pad_out_o  (pad_out),
      .pad_oe_o   (pad_oe)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   ////////////////////
   // Reference model
   ////////////////////
   // First of three candidate pads in Alternate mode, idle high otherwise
   function automatic logic pick_alt_input(stim_t s, int a, int b, int c);
      if (s.mode[a] == pad_ctrl_pkg::MODE_ALT) return s.pad_in[a];
      if (s.mode[b] == pad_ctrl_pkg::MODE_ALT) return s.pad_in[b];
      if (s.mode[c] == pad_ctrl_pkg::MODE_ALT) return s.pad_in[c];
      return 1'b1;
   endfunction

   function automatic resp_t model(stim_t s);
      resp_t      r;
      logic [1:0] f;
      logic [1:0] a;
      logic [1:0] k;
      logic [3:0] t;
      r = '0;
      for (int p = 0; p < pad_ctrl_pkg::NUM_PADS; p++) begin
         // {out, oe} per table
         k = 2'(p - pad_ctrl_pkg::PAD_SDIO_DATA0);
         t = 4'(p - 9);
         case (p)
            0, 1, 2, 3:     f = {s.spi.sdo[p[1:0]], ~s.spi.oen[p[1:0]]};
            4:              f = {s.spi.csn[0], 1'b1};
            5:              f = {s.spi.csn[1], 1'b1};
            6:              f = {s.spi.sck, 1'b1};
            8:              f = {s.uart_tx, 1'b1};
            20:             f = {s.sdio.clk, 1'b1};
            21:             f = {s.sdio.cmd, ~s.sdio.cmd_oen};
            22, 23, 24, 25: f = {s.sdio.data[k], ~s.sdio.data_oen[k]};
            26:             f = {s.i2c0.sda_out, s.i2c0.sda_oe};
            27:             f = {s.i2c0.scl_out, s.i2c0.scl_oe};
            default:        f = 2'b00;
         endcase
         case (p)
            2, 7, 24: a = {s.i2c1.sda_out, s.i2c1.sda_oe};
            3, 8, 25: a = {s.i2c1.scl_out, s.i2c1.scl_oe};
            default:  a = (p >= 9 && p <= 20) ? {s.timer.ch[t[3:2]][t[1:0]], 1'b1} : 2'b00;
         endcase
         case (s.mode[p])
            pad_ctrl_pkg::MODE_FUNC: {r.out[p], r.oe[p]} = f;
            pad_ctrl_pkg::MODE_GPIO: begin
               {r.out[p], r.oe[p]} = {s.gpio_out[p], s.gpio_dir[p]};
               r.gpio_in[p] = s.pad_in[p];
            end
            pad_ctrl_pkg::MODE_ALT:  {r.out[p], r.oe[p]} = a;
            default:                 {r.out[p], r.oe[p]} = 2'b00;
         endcase
         r.cfg[p] = (s.mode[p] == pad_ctrl_pkg::MODE_GPIO) ? s.gpio_cfg[p] : s.pad_cfg[p];
      end
      for (int i = 0; i < 4; i++) begin
         r.periph.spi_sdi[i]   = (s.mode[i] == pad_ctrl_pkg::MODE_FUNC) & s.pad_in[i];
         r.periph.sdio_data[i] = (s.mode[22 + i] == pad_ctrl_pkg::MODE_FUNC) & s.pad_in[22 + i];
      end
      r.periph.sdio_cmd      = (s.mode[21] == pad_ctrl_pkg::MODE_FUNC) & s.pad_in[21];
      r.periph.uart_rx       = (s.mode[7] == pad_ctrl_pkg::MODE_FUNC) ? s.pad_in[7] : 1'b1;
      r.periph.i2c_sda_in[0] = (s.mode[26] == pad_ctrl_pkg::MODE_FUNC) ? s.pad_in[26] : 1'b1;
      r.periph.i2c_scl_in[0] = (s.mode[27] == pad_ctrl_pkg::MODE_FUNC) ? s.pad_in[27] : 1'b1;
      r.periph.i2c_sda_in[1] = pick_alt_input(s, 2, 7, 24);
      r.periph.i2c_scl_in[1] = pick_alt_input(s, 3, 8, 25);
      return r;
   endfunction

   ////////////////////
   // Stimulus
   ////////////////////
   function automatic stim_t random_stim();
      stim_t       s;
      logic [31:0] rnd;
      for (int p = 0; p < pad_ctrl_pkg::NUM_PADS; p++) begin
         rnd = $urandom();
         s.pad_cfg[p]  = rnd[5:0];
         s.gpio_cfg[p] = rnd[11:6];
         s.mode[p]     = rnd[13:12];
      end
      rnd = $urandom();
      s.gpio_out = rnd[27:0];
      rnd = $urandom();
      s.gpio_dir = rnd[27:0];
      rnd = $urandom();
      s.pad_in = rnd[27:0];
      rnd = $urandom();
      s.spi     = rnd[10:0];
      s.sdio    = rnd[21:11];
      s.i2c0    = rnd[25:22];
      s.i2c1    = rnd[29:26];
      s.uart_tx = rnd[30];
      rnd = $urandom();
      s.timer.flat = rnd[15:0];
      return s;
   endfunction

   function automatic stim_t set_all_modes(stim_t s, logic [1:0] m);
      s.mode = {pad_ctrl_pkg::NUM_PADS{m}};
      return s;
   endfunction

   task automatic apply(input stim_t s);
      @(posedge clk);
      stim <= s;
   endtask

   ////////////////////
   // Checks
   ////////////////////
   task automatic check_value(input string name, input logic [31:0] act,
                              input logic [31:0] want);
      assert (act === want)
      else begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, want, act);
      end
   endtask

   always @(negedge clk) begin
      resp_t want;
      if (rst_n) begin
         want = model(stim);
         check_value("pad_out_o", 32'(pad_out), 32'(want.out));
         check_value("pad_oe_o", 32'(pad_oe), 32'(want.oe));
         check_value("gpio_in_o", 32'(gpio_in), 32'(want.gpio_in));
         check_value("periph_o", 32'(periph), 32'(want.periph));
         for (int p = 0; p < pad_ctrl_pkg::NUM_PADS; p++) begin
            check_value($sformatf("pad_cfg_o[%0d]", p), 32'(pad_cfg[p]), 32'(want.cfg[p]));
         end
         // Whole-frame rules, independent of the per-pad tables
         if (stim.mode == {pad_ctrl_pkg::NUM_PADS{pad_ctrl_pkg::MODE_OFF}}) begin
            check_value("pad_oe_o", 32'(pad_oe), 32'd0);
         end
         if (stim.mode == {pad_ctrl_pkg::NUM_PADS{pad_ctrl_pkg::MODE_GPIO}}) begin
            check_value("pad_out_o", 32'(pad_out), 32'(stim.gpio_out));
            check_value("gpio_in_o", 32'(gpio_in), 32'(stim.pad_in));
         end
         num_checks++;
      end
   end

   initial begin
      stim_t s;
      int    base_checks;
      int    cycles;
      errors     = 0;
      num_checks = 0;
      rst_n      = 1'b0;
      stim       = set_all_modes('0, pad_ctrl_pkg::MODE_OFF);
      void'($urandom(SEED));
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      repeat (4) apply(set_all_modes(random_stim(), pad_ctrl_pkg::MODE_OFF));
      repeat (8) apply(set_all_modes(random_stim(), pad_ctrl_pkg::MODE_GPIO));
      repeat (16) apply(set_all_modes(random_stim(), pad_ctrl_pkg::MODE_FUNC));
      repeat (8) apply(set_all_modes(random_stim(), pad_ctrl_pkg::MODE_ALT));

      // I2C1 candidates, every mix of Alternate and GPIO
      for (int c = 0; c < 64; c++) begin
         s = random_stim();
         s.mode[2]  = c[0] ? pad_ctrl_pkg::MODE_ALT : pad_ctrl_pkg::MODE_GPIO;
         s.mode[7]  = c[1] ? pad_ctrl_pkg::MODE_ALT : pad_ctrl_pkg::MODE_GPIO;
         s.mode[24] = c[2] ? pad_ctrl_pkg::MODE_ALT : pad_ctrl_pkg::MODE_GPIO;
         s.mode[3]  = c[3] ? pad_ctrl_pkg::MODE_ALT : pad_ctrl_pkg::MODE_GPIO;
         s.mode[8]  = c[4] ? pad_ctrl_pkg::MODE_ALT : pad_ctrl_pkg::MODE_GPIO;
         s.mode[25] = c[5] ? pad_ctrl_pkg::MODE_ALT : pad_ctrl_pkg::MODE_GPIO;
         apply(s);
      end

      // Walking one through the timer channels
      for (int j = 0; j < 12; j++) begin
         s = set_all_modes(random_stim(), pad_ctrl_pkg::MODE_ALT);
         s.timer = '0;
         s.timer.ch[j / 4] = 4'(1 << (j % 4));
         apply(s);
      end

      base_checks = num_checks;
      cycles      = 0;
      while (num_checks - base_checks < RANDOM_CYCLES && cycles < TIMEOUT_CYCLES) begin
         apply(random_stim());
         cycles++;
      end
      if (num_checks - base_checks < RANDOM_CYCLES) begin
         errors++;
         $display("Timeout: the random phase did not complete its %0d checks", RANDOM_CYCLES);
      end

      @(negedge clk);
      #1;
      $display("Checks: %0d, errors: %0d", num_checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== pad_ctrl.f ====
pad_ctrl_pkg.sv
pad_func_map.sv
pad_out_mux.sv
pad_in_route.sv
pad_ctrl_top.sv
tb_pad_ctrl.sv

// ==== Makefile ====
TOP := tb_pad_ctrl

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f pad_ctrl.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

.PHONY: sim clean
